// ==== sim.f ====
hdl/csr_pkg.sv
hdl/csr_access.sv
hdl/csr_read_mux.sv
hdl/machine_trap_csrs.sv
hdl/debug_csrs.sv
hdl/csr_file.sv
sim/tb_csr_file.sv

// ==== Makefile ====
# Verilator flow for the CSR block

VERILATOR  ?= verilator
FILELIST   ?= sim.f
TB_TOP     ?= tb_csr_file
RTL_TOP    ?= csr_file
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert
PASS_MSG   ?= *** PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_csr_file.sv ====
`timescale 1ns/1ps

module tb_csr_file import csr_pkg::*; ();

  localparam int CLK_PERIOD    = 4;
  localparam int RESET_CYCLES  = 16;
  localparam int TEST_CYCLES   = 300; // six tests need about 200
  localparam int MARGIN_CYCLES = 100;
  localparam int WATCHDOG_NS   = (RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

  logic        clk     = 1'b0;
  logic        rst_n   = 1'b0;
  csr_req_t    csr_req = '{addr: CSR_MSTATUS, op: CSR_OP_READ, wdata: 32'h0};
  trap_ctrl_t  trap    = '0;
  logic [31:0] mip     = '0;
  logic [31:0] csr_rdata;
  logic [23:0] mtvec_base;
  logic [1:0]  mtvec_mode;
  logic [31:0] mepc;
  logic [31:0] depc;
  logic        m_irq_enable;
  logic        single_step;
  logic        ebreakm;

  int          errors    = 0;
  int          tests_run = 0;
  logic [15:0] lfsr      = 16'd18; // seed

  csr_file dut (
    .clk                 (clk),
    .rst_n               (rst_n),
    .csr_req_i           (csr_req),
    .trap_i              (trap),
    .mip_i               (mip),
    .csr_rdata_o         (csr_rdata),
    .mtvec_base_o        (mtvec_base),
    .mtvec_mode_o        (mtvec_mode),
    .mepc_o              (mepc),
    .depc_o              (depc),
    .m_irq_enable_o      (m_irq_enable),
    .debug_single_step_o (single_step),
    .debug_ebreakm_o     (ebreakm)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic next_rand(output logic [31:0] val);
    val = '0;
    for (int b = 0; b < 32; b++) begin
      val  = {val[30:0], lfsr[15]};
      lfsr = lfsr_step(lfsr); // one step per bit
    end
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("CHECK FAILED at %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
  endtask

  task automatic drive_req(input csr_num_e addr, input csr_opcode_e op,
                           input logic [31:0] wdata);
    @(posedge clk);
    csr_req <= '{addr: addr, op: op, wdata: wdata};
    trap    <= '0;
  endtask

  task automatic write_csr(input csr_num_e addr, input logic [31:0] data);
    drive_req(addr, CSR_OP_WRITE, data);
  endtask

  // read data is combinational, sampled mid cycle
  task automatic expect_csr(input csr_num_e addr, input logic [31:0] exp, input string name);
    logic [31:0] got;
    drive_req(addr, CSR_OP_READ, 32'h0);
    @(negedge clk);
    got = csr_rdata;
    if (got !== exp) report_mismatch(name, got, exp);
  endtask

  // one cycle command, regs settle on the edge that drops it
  task automatic pulse_trap(input trap_ctrl_t t);
    @(posedge clk);
    csr_req <= '{addr: CSR_MSTATUS, op: CSR_OP_READ, wdata: 32'h0};
    trap    <= t;
    @(posedge clk);
    trap    <= '0;
    @(negedge clk);
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic test_reset_values();
    tests_run++;
    expect_csr(CSR_MSTATUS, 32'h0000_1800, "mstatus"); // only mpp = M set
    expect_csr(CSR_MTVEC, {30'h0, MTVEC_MODE_RESET}, "mtvec");
    expect_csr(CSR_DCSR, DCSR_RESET, "dcsr");
    expect_csr(CSR_MISA, MISA_VALUE, "misa");
    expect_csr(CSR_MVENDORID, MVENDORID_VALUE, "mvendorid");
    expect_csr(CSR_MARCHID, MARCHID_VALUE, "marchid");
    expect_csr(CSR_MHARTID, 32'h0, "mhartid");
    expect_csr(csr_num_e'(12'h343), 32'h0, "unlisted 0x343"); // mtval, not kept
    if (m_irq_enable !== 1'b0) report_mismatch("m_irq_enable_o", {31'b0, m_irq_enable}, 32'h0);
    @(posedge clk);
    mip <= 32'h0000_0888; // mei, mti, msi pending
    expect_csr(CSR_MIP, 32'h0000_0888, "mip");
  endtask

  task automatic test_access_ops();
    logic [31:0] model;
    tests_run++;
    model = 32'hA5A5_0F0F;
    write_csr(CSR_MSCRATCH, model);
    expect_csr(CSR_MSCRATCH, model, "mscratch write");
    drive_req(CSR_MSCRATCH, CSR_OP_SET, 32'h0000_F0F0);
    model = model | 32'h0000_F0F0;
    expect_csr(CSR_MSCRATCH, model, "mscratch set");
    drive_req(CSR_MSCRATCH, CSR_OP_CLEAR, 32'hA500_00FF);
    model = model & ~32'hA500_00FF;
    expect_csr(CSR_MSCRATCH, model, "mscratch clear");
    drive_req(CSR_MSCRATCH, CSR_OP_READ, 32'hFFFF_FFFF); // wdata ignored
    expect_csr(CSR_MSCRATCH, model, "mscratch read");
  endtask

  task automatic test_write_shaping();
    logic [31:0] wval;
    tests_run++;
    write_csr(CSR_MIE, 32'hFFFF_FFFF);
    expect_csr(CSR_MIE, IRQ_MASK, "mie");
    write_csr(CSR_MEPC, 32'h1234_5677);
    expect_csr(CSR_MEPC, 32'h1234_5676, "mepc");
    if (mepc !== 32'h1234_5676) report_mismatch("mepc_o", mepc, 32'h1234_5676);
    write_csr(CSR_DPC, 32'h8000_0011);
    expect_csr(CSR_DPC, 32'h8000_0010, "dpc");
    if (depc !== 32'h8000_0010) report_mismatch("depc_o", depc, 32'h8000_0010);
    wval = 32'hDEAD_BEEF;
    write_csr(CSR_MTVEC, wval);
    expect_csr(CSR_MTVEC, 32'hDEAD_BE01, "mtvec"); // base DEADBE, mode 1
    if (mtvec_base !== 24'hDE_ADBE)
      report_mismatch("mtvec_base_o", {8'h0, mtvec_base}, 32'h00DE_ADBE);
    if (mtvec_mode !== 2'b01)
      report_mismatch("mtvec_mode_o", {30'h0, mtvec_mode}, 32'h1);
    wval = 32'h8000_07F3;
    write_csr(CSR_MCAUSE, wval);
    expect_csr(CSR_MCAUSE, 32'h8000_0013, "mcause"); // bits 10:5 dropped
    write_csr(CSR_DCSR, 32'hFFFF_FFFF); // only ebreakm, stepie, step move
    expect_csr(CSR_DCSR, DCSR_RESET | 32'h0000_8804, "dcsr all ones");
    if (ebreakm !== 1'b1) report_mismatch("debug_ebreakm_o", {31'b0, ebreakm}, 32'h1);
    write_csr(CSR_DCSR, 32'h0);
    expect_csr(CSR_DCSR, DCSR_RESET, "dcsr zero");
  endtask

  task automatic test_trap_mret();
    trap_ctrl_t  t;
    logic [31:0] pc;
    tests_run++;
    write_csr(CSR_MSTATUS, 32'h1 << MSTATUS_MIE_BIT);
    expect_csr(CSR_MSTATUS, 32'h0000_1808, "mstatus mie set");
    pc           = 32'h8000_0105;
    t            = '0;
    t.save_cause = 1'b1;
    t.cause      = 6'h2B; // irq 11
    t.pc         = pc;
    pulse_trap(t);
    if (mepc !== 32'h8000_0104) report_mismatch("mepc_o", mepc, 32'h8000_0104);
    expect_csr(CSR_MCAUSE, 32'h8000_000B, "mcause after trap"); // irq flag in bit 31
    expect_csr(CSR_MSTATUS, 32'h0000_1880, "mstatus after trap"); // mie 0, mpie 1
    if (m_irq_enable !== 1'b0) report_mismatch("m_irq_enable_o", {31'b0, m_irq_enable}, 32'h0);
    t              = '0;
    t.restore_mret = 1'b1;
    pulse_trap(t);
    expect_csr(CSR_MSTATUS, 32'h0000_1888, "mstatus after mret");
    if (m_irq_enable !== 1'b1) report_mismatch("m_irq_enable_o", {31'b0, m_irq_enable}, 32'h1);
  endtask

  task automatic test_debug_step();
    trap_ctrl_t  t;
    logic [31:0] dcsr_exp;
    tests_run++;
    t             = '0;
    t.save_cause  = 1'b1;
    t.debug_save  = 1'b1;
    t.debug_cause = 3'd3;
    t.cause       = 6'h03; // must not reach mcause
    t.pc          = 32'h0000_2003;
    pulse_trap(t);
    if (depc !== 32'h0000_2002) report_mismatch("depc_o", depc, 32'h0000_2002);
    if (mepc !== 32'h8000_0104) report_mismatch("mepc_o", mepc, 32'h8000_0104);
    dcsr_exp = DCSR_RESET | (32'(t.debug_cause) << 6);
    expect_csr(CSR_DCSR, dcsr_exp, "dcsr after debug entry");
    expect_csr(CSR_MSTATUS, 32'h0000_1888, "mstatus after debug entry");
    expect_csr(CSR_MCAUSE, 32'h8000_000B, "mcause after debug entry"); // still irq 11
    // step without stepie masks irqs
    write_csr(CSR_DCSR, 32'h0000_0004);
    dcsr_exp = dcsr_exp | 32'h0000_0004;
    expect_csr(CSR_DCSR, dcsr_exp, "dcsr step");
    if (m_irq_enable !== 1'b0) report_mismatch("m_irq_enable_o", {31'b0, m_irq_enable}, 32'h0);
    if (single_step !== 1'b1)
      report_mismatch("debug_single_step_o", {31'b0, single_step}, 32'h1);
    drive_req(CSR_DCSR, CSR_OP_SET, 32'h0000_0800); // stepie
    dcsr_exp = dcsr_exp | 32'h0000_0800;
    expect_csr(CSR_DCSR, dcsr_exp, "dcsr stepie");
    if (m_irq_enable !== 1'b1) report_mismatch("m_irq_enable_o", {31'b0, m_irq_enable}, 32'h1);
  endtask

  task automatic test_scratch_regs();
    logic [31:0] v0;
    logic [31:0] v1;
    logic [31:0] v2;
    tests_run++;
    for (int i = 0; i < 20; i++) begin
      next_rand(v0);
      next_rand(v1);
      next_rand(v2);
      write_csr(CSR_MSCRATCH, v0);
      write_csr(CSR_DSCRATCH0, v1);
      write_csr(CSR_DSCRATCH1, v2);
      expect_csr(CSR_MSCRATCH, v0, "mscratch");
      expect_csr(CSR_DSCRATCH0, v1, "dscratch0");
      expect_csr(CSR_DSCRATCH1, v2, "dscratch1");
    end
  endtask

  //////////////////////////////
  // sequence and report
  //////////////////////////////

  initial begin
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_values();
    test_access_ops();
    test_write_shaping();
    test_trap_mret();
    test_debug_step();
    test_scratch_regs();
    @(posedge clk);
    $display("summary: %0d tests run, %0d errors", tests_run, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== hdl/csr_file.sv ====
`timescale 1ns/1ps

module csr_file import csr_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  csr_req_t    csr_req_i,
  input  trap_ctrl_t  trap_i,
  input  logic [31:0] mip_i,
  output logic [31:0] csr_rdata_o,
  output logic [23:0] mtvec_base_o,
  output logic [1:0]  mtvec_mode_o,
  output logic [31:0] mepc_o,
  output logic [31:0] depc_o,
  output logic        m_irq_enable_o,
  output logic        debug_single_step_o,
  output logic        debug_ebreakm_o
);

  csr_wr_t     csr_wr;       // resolved write, both groups decode it
  logic [31:0] mstatus;
  logic [31:0] mie;
  logic [31:0] mtvec;
  logic [31:0] mscratch;
  logic [31:0] mcause;
  logic [31:0] dcsr;
  logic [31:0] dscratch0;
  logic [31:0] dscratch1;
  logic        mstatus_mie;  // feeds irq gating in the debug group

  //////////////////////////////
  // access and read path
  //////////////////////////////

  csr_access u_access (
    .req_i   (csr_req_i),
    .rdata_i (csr_rdata_o),
    .wr_o    (csr_wr)
  );

  csr_read_mux u_read_mux (
    .addr_i      (csr_req_i.addr),
    .mstatus_i   (mstatus),
    .mie_i       (mie),
    .mip_i       (mip_i),
    .mtvec_i     (mtvec),
    .mscratch_i  (mscratch),
    .mepc_i      (mepc_o),
    .mcause_i    (mcause),
    .dcsr_i      (dcsr),
    .dpc_i       (depc_o),
    .dscratch0_i (dscratch0),
    .dscratch1_i (dscratch1),
    .rdata_o     (csr_rdata_o)
  );

  //////////////////////////////
  // register groups
  //////////////////////////////

  machine_trap_csrs u_machine (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_i          (csr_wr),
    .trap_i        (trap_i),
    .mstatus_o     (mstatus),
    .mie_o         (mie),
    .mtvec_o       (mtvec),
    .mscratch_o    (mscratch),
    .mepc_o        (mepc_o),
    .mcause_o      (mcause),
    .mtvec_base_o  (mtvec_base_o),
    .mtvec_mode_o  (mtvec_mode_o),
    .mstatus_mie_o (mstatus_mie)
  );

  debug_csrs u_debug (
    .clk                 (clk),
    .rst_n               (rst_n),
    .wr_i                (csr_wr),
    .trap_i              (trap_i),
    .mstatus_mie_i       (mstatus_mie),
    .dcsr_o              (dcsr),
    .dpc_o               (depc_o),
    .dscratch0_o         (dscratch0),
    .dscratch1_o         (dscratch1),
    .m_irq_enable_o      (m_irq_enable_o),
    .debug_single_step_o (debug_single_step_o),
    .debug_ebreakm_o     (debug_ebreakm_o)
  );

endmodule

// ==== hdl/debug_csrs.sv ====
`timescale 1ns/1ps

module debug_csrs import csr_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  csr_wr_t     wr_i,
  input  trap_ctrl_t  trap_i,
  input  logic        mstatus_mie_i,
  output logic [31:0] dcsr_o,
  output logic [31:0] dpc_o,
  output logic [31:0] dscratch0_o,
  output logic [31:0] dscratch1_o,
  output logic        m_irq_enable_o,
  output logic        debug_single_step_o,
  output logic        debug_ebreakm_o
);

  // dcsr layout, 32 bits
  typedef struct packed {
    logic [3:0]  xdebugver;
    logic [11:0] zero2;
    logic        ebreakm;   // 15
    logic        zero1;
    logic        ebreaks;
    logic        ebreaku;
    logic        stepie;    // 11
    logic        stopcount;
    logic        stoptime;
    logic [2:0]  cause;     // 8:6
    logic        zero0;
    logic        mprven;
    logic        nmip;
    logic        step;      // 2
    priv_lvl_e   prv;
  } dcsr_t;

  dcsr_t       dcsr_q, dcsr_n;
  logic [31:0] dpc_q, dpc_n;
  logic [31:0] dscratch0_q, dscratch0_n;
  logic [31:0] dscratch1_q, dscratch1_n;

  //////////////////////////////
  // next state
  //////////////////////////////

  always_comb begin
    dcsr_n      = dcsr_q;
    dpc_n       = dpc_q;
    dscratch0_n = dscratch0_q;
    dscratch1_n = dscratch1_q;

    if (wr_i.we) begin
      case (wr_i.addr)
        CSR_DCSR: begin
          dcsr_n.ebreakm = wr_i.data[15];
          dcsr_n.stepie  = wr_i.data[11];
          dcsr_n.step    = wr_i.data[2];
        end
        CSR_DPC:       dpc_n       = {wr_i.data[31:1], 1'b0};
        CSR_DSCRATCH0: dscratch0_n = wr_i.data;
        CSR_DSCRATCH1: dscratch1_n = wr_i.data;
        default: ;
      endcase
    end

    // debug entry, machine regs untouched
    if (trap_i.save_cause && trap_i.debug_save) begin
      dcsr_n.cause = trap_i.debug_cause;
      dpc_n        = {trap_i.pc[31:1], 1'b0};
    end

    dcsr_n.xdebugver = XDEBUGVER_STD; // read only
    dcsr_n.prv       = PRIV_LVL_M;    // only M exists
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dcsr_q      <= dcsr_t'(DCSR_RESET);
      dpc_q       <= '0;
      dscratch0_q <= '0;
      dscratch1_q <= '0;
    end else begin
      dcsr_q      <= dcsr_n;
      dpc_q       <= dpc_n;
      dscratch0_q <= dscratch0_n;
      dscratch1_q <= dscratch1_n;
    end
  end

  assign dcsr_o      = dcsr_q;
  assign dpc_o       = dpc_q;
  assign dscratch0_o = dscratch0_q;
  assign dscratch1_o = dscratch1_q;

  // stepping without stepie masks irqs
  assign m_irq_enable_o      = mstatus_mie_i && !(dcsr_q.step && !dcsr_q.stepie);
  assign debug_single_step_o = dcsr_q.step;
  assign debug_ebreakm_o     = dcsr_q.ebreakm;

  // debug entry rides on a save_cause from the controller
  a_debug_save_qual: assert property (
    @(posedge clk) disable iff (!rst_n)
    trap_i.debug_save |-> trap_i.save_cause
  ) else $error("debug_csrs: debug_save without save_cause");

endmodule

// ==== hdl/machine_trap_csrs.sv ====
`timescale 1ns/1ps

module machine_trap_csrs import csr_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  csr_wr_t     wr_i,
  input  trap_ctrl_t  trap_i,
  output logic [31:0] mstatus_o,
  output logic [31:0] mie_o,
  output logic [31:0] mtvec_o,
  output logic [31:0] mscratch_o,
  output logic [31:0] mepc_o,
  output logic [31:0] mcause_o,
  output logic [23:0] mtvec_base_o,
  output logic [1:0]  mtvec_mode_o,
  output logic        mstatus_mie_o
);

  // only the enable bits are stored, mpp is hardwired
  typedef struct packed {
    logic mie;
    logic mpie;
  } mstatus_t;

  mstatus_t    mstatus_q, mstatus_n;
  logic [31:0] mie_q, mie_n;
  logic [23:0] mtvec_base_q, mtvec_base_n;
  logic [1:0]  mtvec_mode_q, mtvec_mode_n;
  logic [31:0] mscratch_q, mscratch_n;
  logic [31:0] mepc_q, mepc_n;
  logic [5:0]  mcause_q, mcause_n; // irq flag + 5 bit code

  //////////////////////////////
  // next state
  //////////////////////////////

  always_comb begin
    mstatus_n    = mstatus_q;
    mie_n        = mie_q;
    mtvec_base_n = mtvec_base_q;
    mtvec_mode_n = mtvec_mode_q;
    mscratch_n   = mscratch_q;
    mepc_n       = mepc_q;
    mcause_n     = mcause_q;

    // software writes first
    if (wr_i.we) begin
      case (wr_i.addr)
        CSR_MSTATUS: begin
          mstatus_n.mie  = wr_i.data[MSTATUS_MIE_BIT];
          mstatus_n.mpie = wr_i.data[MSTATUS_MPIE_BIT];
        end
        CSR_MIE:      mie_n = wr_i.data & IRQ_MASK;
        CSR_MTVEC: begin
          mtvec_base_n = wr_i.data[31:8];
          mtvec_mode_n = {1'b0, wr_i.data[0]}; // direct or vectored only
        end
        CSR_MSCRATCH: mscratch_n = wr_i.data;
        CSR_MEPC:     mepc_n     = {wr_i.data[31:1], 1'b0}; // halfword aligned
        CSR_MCAUSE:   mcause_n   = {wr_i.data[31], wr_i.data[4:0]};
        default: ;
      endcase
    end

    // controller overrides the fields it touches
    if (trap_i.save_cause && !trap_i.debug_save) begin
      mstatus_n.mpie = mstatus_q.mie;
      mstatus_n.mie  = 1'b0;                     // irqs off in handler
      mepc_n         = {trap_i.pc[31:1], 1'b0};
      mcause_n       = trap_i.cause;
    end else if (trap_i.restore_mret) begin
      mstatus_n.mie  = mstatus_q.mpie;
      mstatus_n.mpie = 1'b1;
    end
  end

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q    <= '0;
      mie_q        <= '0;
      mtvec_base_q <= '0;
      mtvec_mode_q <= MTVEC_MODE_RESET;
      mscratch_q   <= '0;
      mepc_q       <= '0;
      mcause_q     <= '0;
    end else begin
      mstatus_q    <= mstatus_n;
      mie_q        <= mie_n;
      mtvec_base_q <= mtvec_base_n;
      mtvec_mode_q <= mtvec_mode_n;
      mscratch_q   <= mscratch_n;
      mepc_q       <= mepc_n;
      mcause_q     <= mcause_n;
    end
  end

  // read views
  // mpp always M, so mstatus reads 32'h1800 out of reset
  always_comb begin
    mstatus_o                         = '0;
    mstatus_o[MSTATUS_MIE_BIT]        = mstatus_q.mie;
    mstatus_o[MSTATUS_MPIE_BIT]       = mstatus_q.mpie;
    mstatus_o[MSTATUS_MPP_LO +: 2]    = PRIV_LVL_M;
  end

  assign mie_o         = mie_q;
  assign mtvec_o       = {mtvec_base_q, 6'b0, mtvec_mode_q};
  assign mscratch_o    = mscratch_q;
  assign mepc_o        = mepc_q;
  assign mcause_o      = {mcause_q[5], 26'b0, mcause_q[4:0]}; // irq flag to bit 31
  assign mtvec_base_o  = mtvec_base_q;
  assign mtvec_mode_o  = mtvec_mode_q;
  assign mstatus_mie_o = mstatus_q.mie;

  // controller never enters and leaves a trap in one cycle
  a_trap_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(trap_i.save_cause && trap_i.restore_mret)
  ) else $error("machine_trap_csrs: save_cause and restore_mret together");

endmodule

// ==== hdl/csr_read_mux.sv ====
`timescale 1ns/1ps

module csr_read_mux import csr_pkg::*; (
  input  csr_num_e    addr_i,
  // machine group
  input  logic [31:0] mstatus_i,
  input  logic [31:0] mie_i,
  input  logic [31:0] mip_i,
  input  logic [31:0] mtvec_i,
  input  logic [31:0] mscratch_i,
  input  logic [31:0] mepc_i,
  input  logic [31:0] mcause_i,
  // debug group
  input  logic [31:0] dcsr_i,
  input  logic [31:0] dpc_i,
  input  logic [31:0] dscratch0_i,
  input  logic [31:0] dscratch1_i,
  output logic [31:0] rdata_o
);

  //////////////////////////////
  // read select
  //////////////////////////////

  always_comb begin
    case (addr_i)
      // information regs, constants
      CSR_MVENDORID: rdata_o = MVENDORID_VALUE;
      CSR_MARCHID:   rdata_o = MARCHID_VALUE;
      CSR_MIMPID:    rdata_o = '0; // no implementation id
      CSR_MHARTID:   rdata_o = '0; // single hart
      CSR_MISA:      rdata_o = MISA_VALUE;

      // trap setup
      CSR_MSTATUS:   rdata_o = mstatus_i;
      CSR_MIE:       rdata_o = mie_i;
      CSR_MTVEC:     rdata_o = mtvec_i;

      // trap handling
      CSR_MSCRATCH:  rdata_o = mscratch_i;
      CSR_MEPC:      rdata_o = mepc_i;
      CSR_MCAUSE:    rdata_o = mcause_i;
      CSR_MIP:       rdata_o = mip_i; // straight from the irq lines

      // debug
      CSR_DCSR:      rdata_o = dcsr_i;
      CSR_DPC:       rdata_o = dpc_i;
      CSR_DSCRATCH0: rdata_o = dscratch0_i;
      CSR_DSCRATCH1: rdata_o = dscratch1_i;

      // mtval, mcounteren, contexts etc. land here
      default:       rdata_o = '0;
    endcase
  end

endmodule

// ==== hdl/csr_access.sv ====
`timescale 1ns/1ps

module csr_access import csr_pkg::*; (
  input  csr_req_t    req_i,
  input  logic [31:0] rdata_i, // current value at req_i.addr
  output csr_wr_t     wr_o
);

  //////////////////////////////
  // read-modify-write
  //////////////////////////////

  always_comb begin
    wr_o.we   = 1'b1;
    wr_o.addr = req_i.addr;
    wr_o.data = req_i.wdata;
    unique case (req_i.op)
      CSR_OP_WRITE: wr_o.data = req_i.wdata;
      CSR_OP_SET:   wr_o.data = req_i.wdata | rdata_i;    // set bits
      CSR_OP_CLEAR: wr_o.data = ~req_i.wdata & rdata_i;   // clear bits
      CSR_OP_READ: begin
        wr_o.we   = 1'b0; // plain read, nothing stored
        wr_o.data = req_i.wdata;
      end
    endcase
  end

  // no request strobe, so the opcode must be defined every cycle
  // and the controller drives READ while idle
  always_comb begin
    assert final (!$isunknown(req_i.op))
      else $error("csr_access: unknown opcode %b", req_i.op);
  end

endmodule

// ==== hdl/csr_pkg.sv ====
package csr_pkg;

  //////////////////////////////
  // csr addresses
  //////////////////////////////

  typedef enum logic [11:0] {
    // machine information, read only
    CSR_MVENDORID = 12'hF11,
    CSR_MARCHID   = 12'hF12,
    CSR_MIMPID    = 12'hF13,
    CSR_MHARTID   = 12'hF14,
    // machine trap setup
    CSR_MSTATUS   = 12'h300,
    CSR_MISA      = 12'h301,
    CSR_MIE       = 12'h304,
    CSR_MTVEC     = 12'h305,
    // machine trap handling
    CSR_MSCRATCH  = 12'h340,
    CSR_MEPC      = 12'h341,
    CSR_MCAUSE    = 12'h342,
    CSR_MIP       = 12'h344,
    // debug mode only
    CSR_DCSR      = 12'h7B0,
    CSR_DPC       = 12'h7B1,
    CSR_DSCRATCH0 = 12'h7B2,
    CSR_DSCRATCH1 = 12'h7B3
  } csr_num_e;

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00, // no write
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_opcode_e;

  typedef enum logic [1:0] {
    PRIV_LVL_M = 2'b11 // machine mode only
  } priv_lvl_e;

  //////////////////////////////
  // bundles
  //////////////////////////////

  // one access per cycle from the decoder
  typedef struct packed {
    csr_num_e    addr;
    csr_opcode_e op;
    logic [31:0] wdata;
  } csr_req_t;

  // resolved write after read-modify-write
  typedef struct packed {
    logic        we;
    csr_num_e    addr;
    logic [31:0] data;
  } csr_wr_t;

  // commands from the controller
  typedef struct packed {
    logic        save_cause;   // trap or debug entry
    logic        debug_save;   // entry goes to debug regs
    logic        restore_mret;
    logic [5:0]  cause;        // bit 5 flags an interrupt
    logic [2:0]  debug_cause;
    logic [31:0] pc;           // exception pc
  } trap_ctrl_t;

  //////////////////////////////
  // bit positions and values
  //////////////////////////////

  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LO   = 11; // mpp at 12:11

  localparam logic [31:0] IRQ_MASK = 32'hFFFF_0888; // fast irqs, mei, mti, msi

  // rv32, I only
  localparam logic [31:0] MISA_VALUE      = 32'h4000_0100;
  localparam logic [31:0] MVENDORID_VALUE = 32'h0000_0A5A;
  localparam logic [31:0] MARCHID_VALUE   = 32'h0000_0023;

  localparam logic [1:0]  MTVEC_MODE_RESET = 2'b01; // vectored
  localparam logic [3:0]  XDEBUGVER_STD    = 4'd4;  // external debug spec
  localparam logic [31:0] DCSR_RESET       = 32'h4000_0003; // xdebugver 4, prv M

endpackage
